// File: common/pdec_cfg_pkg.sv
// Register map, version constant and parameter field types of the
// polar decoder front end. Used by scoped names from the APB block and the fetch.
`default_nettype none

package pdec_cfg_pkg;

  localparam logic [31:0] PDEC_CFG_VER = 32'h0000_0000;

  // ==================================================
  // apb register map
  // ==================================================
  typedef logic [7:0] reg_off_t;

  localparam reg_off_t OFF_VERSION   = 8'h00;
  localparam reg_off_t OFF_CTRL      = 8'h04;
  localparam reg_off_t OFF_STATUS    = 8'h08;
  localparam reg_off_t OFF_PARA_BASE = 8'h0C;
  localparam reg_off_t OFF_PARAM_N   = 8'h10;
  localparam reg_off_t OFF_PARAM_A   = 8'h14;
  localparam reg_off_t OFF_PARAM_K   = 8'h18;

  // ==================================================
  // parameter fields
  // ==================================================
  typedef logic [7:0] param_k_t;
  typedef logic [2:0] param_n_t;
  typedef logic [1:0] word_idx_t;

  localparam int FETCH_WORDS = 3;

  // word order in the parameter memory
  localparam word_idx_t IDX_N = 2'd0;
  localparam word_idx_t IDX_A = 2'd1;
  localparam word_idx_t IDX_K = 2'd2;

  typedef struct packed {
    logic        valid;
    word_idx_t   idx;
    logic [31:0] data;
  } fetch_word_t;

endpackage

`default_nettype wire

// File: common/pdec_mem_pkg.sv
// Widths and request structs of the shared parameter SRAM.
// Used by scoped names from the top, the arbiter, the fetch and the memory.
`default_nettype none

package pdec_mem_pkg;

  typedef logic [12:0] sram_addr_t;
  typedef logic [31:0] sram_data_t;
  typedef logic [7:0]  para_addr_t;

  localparam int PARA_NUM_DEF = 155;

  // host strobe port, write and read may be set together
  typedef struct packed {
    logic       wen;
    sram_addr_t waddr;
    sram_data_t wdata;
    logic       ren;
    sram_addr_t raddr;
  } host_req_t;

  // single port towards the memory
  typedef struct packed {
    logic       en;
    logic       we;
    para_addr_t addr;
    sram_data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic       ren;
    para_addr_t addr;
  } fetch_req_t;

endpackage

`default_nettype wire

// File: sram/pdec_para_sram.sv
// Single-port parameter memory with a registered read.
// Addresses at or above DEPTH are ignored on write and read back as 0.
`timescale 1ns/1ps
`default_nettype none

module pdec_para_sram #(
  parameter int DEPTH = pdec_mem_pkg::PARA_NUM_DEF
) (
  input  logic                     clk,
  input  pdec_mem_pkg::mem_req_t   mem_req,
  output pdec_mem_pkg::sram_data_t rdata
);

  pdec_mem_pkg::sram_data_t mem [DEPTH];
  logic                     in_range;

  assign in_range = (int'(mem_req.addr) < DEPTH);

  always_ff @(posedge clk) begin
    if (mem_req.en) begin
      if (mem_req.we) begin
        if (in_range) begin
          mem[mem_req.addr] <= mem_req.wdata;
        end
      end else begin
        rdata <= in_range ? mem[mem_req.addr] : '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sram/pdec_sram_arb.sv
// Fixed-priority arbiter on the parameter SRAM port. The host always wins,
// fetch reads go only in idle host cycles. Read data is routed to its owner.
`timescale 1ns/1ps
`default_nettype none

module pdec_sram_arb (
  input  logic                     clk,
  input  logic                     arst_n,
  input  pdec_mem_pkg::host_req_t  host_req,
  input  pdec_mem_pkg::fetch_req_t fetch_req,
  input  pdec_mem_pkg::sram_data_t mem_rdata,
  output pdec_mem_pkg::mem_req_t   mem_req,
  output logic                     fetch_gnt,
  output pdec_mem_pkg::sram_data_t fetch_rdata,
  output pdec_mem_pkg::sram_data_t host_rdata
);

  logic host_rd;
  logic rd_vld;
  logic rd_host;

  // write beats read on the host side
  assign host_rd   = host_req.ren & ~host_req.wen;
  assign fetch_gnt = fetch_req.ren & ~host_req.wen & ~host_req.ren;

  always_comb begin
    mem_req = '0;
    if (host_req.wen) begin
      mem_req.en    = 1'b1;
      mem_req.we    = 1'b1;
      mem_req.addr  = host_req.waddr[7:0];
      mem_req.wdata = host_req.wdata;
    end else if (host_req.ren) begin
      mem_req.en   = 1'b1;
      mem_req.addr = host_req.raddr[7:0];
    end else if (fetch_gnt) begin
      mem_req.en   = 1'b1;
      mem_req.addr = fetch_req.addr;
    end
  end

  // owner of the read in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld  <= 1'b0;
      rd_host <= 1'b0;
    end else begin
      rd_vld  <= host_rd | fetch_gnt;
      rd_host <= host_rd;
    end
  end

  // held until the next host read
  always_ff @(posedge clk) begin
    if (rd_vld && rd_host) begin
      host_rdata <= mem_rdata;
    end
  end

  assign fetch_rdata = (rd_vld && !rd_host) ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: hdl/pdec_para_fetch.sv
// Fetch engine: after a start pulse reads N, A and K from base, base+1, base+2.
// Requests wait for a grant; returned words are tagged with their index.
`timescale 1ns/1ps
`default_nettype none

module pdec_para_fetch (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      para_st,
  input  pdec_mem_pkg::para_addr_t  para_base,
  input  logic                      fetch_gnt,
  input  pdec_mem_pkg::sram_data_t  fetch_rdata,
  output pdec_mem_pkg::fetch_req_t  fetch_req,
  output logic                      busy,
  output pdec_cfg_pkg::fetch_word_t fetch_word
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_LAST
  } state_t;

  state_t                   state;
  pdec_cfg_pkg::word_idx_t  cnt;
  pdec_cfg_pkg::word_idx_t  rtn_idx;
  pdec_mem_pkg::para_addr_t base_q;
  logic                     rtn_vld;
  logic                     last_gnt;

  assign last_gnt = fetch_gnt &&
                    (cnt == pdec_cfg_pkg::word_idx_t'(pdec_cfg_pkg::FETCH_WORDS - 1));
  assign busy     = (state != ST_IDLE);

  assign fetch_req  = '{ren:  (state == ST_READ),
                        addr: base_q + pdec_mem_pkg::para_addr_t'(cnt)};
  // data comes back one cycle after the grant
  assign fetch_word = '{valid: rtn_vld, idx: rtn_idx, data: fetch_rdata};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      rtn_vld <= 1'b0;
      rtn_idx <= '0;
    end else begin
      rtn_vld <= fetch_gnt;
      if (fetch_gnt) begin
        rtn_idx <= cnt;
      end
      case (state)
        ST_IDLE: begin
          if (para_st) begin
            state <= ST_READ;
            cnt   <= '0;
          end
        end
        ST_READ: begin
          if (fetch_gnt) begin
            cnt <= cnt + 2'd1;
          end
          if (last_gnt) begin
            state <= ST_LAST;
          end
        end
        // last word returning
        ST_LAST: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // base held for the whole fetch
  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && para_st) begin
      base_q <= para_base;
    end
  end

endmodule

`default_nettype wire

// File: apb_regs/pdec_apb_regs.sv
// APB slave holding control, status, base address and the fetched parameters.
// Zero wait states; writes land on the access edge, reads are combinational.
`timescale 1ns/1ps
`default_nettype none

module pdec_apb_regs (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               paddr,
  input  logic [31:0]               pwdata,
  input  logic                      busy,
  input  pdec_cfg_pkg::fetch_word_t fetch_word,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      para_st,
  output pdec_mem_pkg::para_addr_t  para_base,
  output logic                      pdec_int
);

  pdec_cfg_pkg::reg_off_t off;
  pdec_cfg_pkg::param_n_t param_n;
  pdec_cfg_pkg::param_k_t param_a;
  pdec_cfg_pkg::param_k_t param_k;
  logic                   access;
  logic                   hi_zero;
  logic                   mapped;
  logic                   writable;
  logic                   wr_en;
  logic                   int_en;
  logic                   done;
  logic [31:0]            rd_data;

  // ==================================================
  // address decode
  // ==================================================
  assign off     = paddr[7:0];
  assign access  = psel & penable;
  assign hi_zero = (paddr[31:8] == '0);

  always_comb begin
    mapped   = 1'b1;
    writable = 1'b0;
    rd_data  = '0;
    case (off)
      pdec_cfg_pkg::OFF_VERSION: rd_data = pdec_cfg_pkg::PDEC_CFG_VER;
      pdec_cfg_pkg::OFF_CTRL: begin
        writable = 1'b1;
        // start always reads back as 0
        rd_data  = {30'd0, int_en, 1'b0};
      end
      pdec_cfg_pkg::OFF_STATUS: begin
        writable = 1'b1;
        rd_data  = {30'd0, busy, done};
      end
      pdec_cfg_pkg::OFF_PARA_BASE: begin
        writable = 1'b1;
        rd_data  = {24'd0, para_base};
      end
      pdec_cfg_pkg::OFF_PARAM_N: rd_data = {29'd0, param_n};
      pdec_cfg_pkg::OFF_PARAM_A: rd_data = {24'd0, param_a};
      pdec_cfg_pkg::OFF_PARAM_K: rd_data = {24'd0, param_k};
      default: mapped = 1'b0;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = access & (~hi_zero | ~mapped | (pwrite & ~writable));
  assign prdata  = hi_zero ? rd_data : '0;
  assign wr_en   = access & pwrite & hi_zero & writable;

  // ==================================================
  // control registers
  // ==================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      int_en    <= 1'b0;
      para_base <= '0;
      para_st   <= 1'b0;
    end else begin
      para_st <= wr_en && (off == pdec_cfg_pkg::OFF_CTRL) && pwdata[0];
      if (wr_en && (off == pdec_cfg_pkg::OFF_CTRL)) begin
        int_en <= pwdata[1];
      end
      if (wr_en && (off == pdec_cfg_pkg::OFF_PARA_BASE)) begin
        para_base <= pwdata[7:0];
      end
    end
  end

  // set wins over a clear in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      done     <= 1'b0;
      pdec_int <= 1'b0;
    end else begin
      if (fetch_word.valid && (fetch_word.idx == pdec_cfg_pkg::IDX_K)) begin
        done <= 1'b1;
      end else if (wr_en && (off == pdec_cfg_pkg::OFF_STATUS) && pwdata[0]) begin
        done <= 1'b0;
      end
      pdec_int <= done & int_en;
    end
  end

  // fetched words
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      param_n <= '0;
      param_a <= '0;
      param_k <= '0;
    end else if (fetch_word.valid) begin
      case (fetch_word.idx)
        pdec_cfg_pkg::IDX_N: param_n <= fetch_word.data[2:0];
        pdec_cfg_pkg::IDX_A: param_a <= fetch_word.data[7:0];
        pdec_cfg_pkg::IDX_K: param_k <= fetch_word.data[7:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/pdec_wrap.sv
// Top of the decoder parameter front end: APB registers, fetch engine,
// arbiter and parameter SRAM. PARA_NUM sets the memory depth.
`timescale 1ns/1ps
`default_nettype none

module pdec_wrap #(
  parameter int PARA_NUM = pdec_mem_pkg::PARA_NUM_DEF
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     pdec_psel,
  input  logic                     pdec_penable,
  input  logic                     pdec_pwrite,
  input  logic [31:0]              pdec_paddr,
  input  logic [31:0]              pdec_pwdata,
  output logic [31:0]              pdec_prdata,
  output logic                     pdec_pready,
  output logic                     pdec_pslverr,
  input  logic                     pdec_sram_wen,
  input  pdec_mem_pkg::sram_addr_t pdec_sram_waddr,
  input  pdec_mem_pkg::sram_data_t pdec_sram_wdata,
  input  logic                     pdec_sram_ren,
  input  pdec_mem_pkg::sram_addr_t pdec_sram_raddr,
  output pdec_mem_pkg::sram_data_t pdec_sram_rdata,
  output logic                     pdec_int
);

  pdec_mem_pkg::host_req_t   host_req;
  pdec_mem_pkg::fetch_req_t  fetch_req;
  pdec_mem_pkg::mem_req_t    mem_req;
  pdec_mem_pkg::sram_data_t  mem_rdata;
  pdec_mem_pkg::sram_data_t  fetch_rdata;
  pdec_mem_pkg::para_addr_t  para_base;
  pdec_cfg_pkg::fetch_word_t fetch_word;
  logic                      fetch_gnt;
  logic                      para_st;
  logic                      busy;

  assign host_req = '{wen:   pdec_sram_wen,
                      waddr: pdec_sram_waddr,
                      wdata: pdec_sram_wdata,
                      ren:   pdec_sram_ren,
                      raddr: pdec_sram_raddr};

  pdec_apb_regs u_pdec_apb_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .psel       (pdec_psel),
    .penable    (pdec_penable),
    .pwrite     (pdec_pwrite),
    .paddr      (pdec_paddr),
    .pwdata     (pdec_pwdata),
    .busy       (busy),
    .fetch_word (fetch_word),
    .prdata     (pdec_prdata),
    .pready     (pdec_pready),
    .pslverr    (pdec_pslverr),
    .para_st    (para_st),
    .para_base  (para_base),
    .pdec_int   (pdec_int)
  );

  pdec_para_fetch u_pdec_para_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .para_st     (para_st),
    .para_base   (para_base),
    .fetch_gnt   (fetch_gnt),
    .fetch_rdata (fetch_rdata),
    .fetch_req   (fetch_req),
    .busy        (busy),
    .fetch_word  (fetch_word)
  );

  pdec_sram_arb u_pdec_sram_arb (
    .clk         (clk),
    .arst_n      (arst_n),
    .host_req    (host_req),
    .fetch_req   (fetch_req),
    .mem_rdata   (mem_rdata),
    .mem_req     (mem_req),
    .fetch_gnt   (fetch_gnt),
    .fetch_rdata (fetch_rdata),
    .host_rdata  (pdec_sram_rdata)
  );

  pdec_para_sram #(
    .DEPTH (PARA_NUM)
  ) u_pdec_para_sram (
    .clk     (clk),
    .mem_req (mem_req),
    .rdata   (mem_rdata)
  );

endmodule

`default_nettype wire

// File: test/pdec_wrap_assertions.sv
// Checker bound into pdec_wrap. Mirrors host writes and the APB control state
// and checks bus responses, host read data and the interrupt with assertions.
`timescale 1ns/1ps
`default_nettype none

module pdec_wrap_assertions #(
  parameter int PARA_NUM = 155
) (
  input logic        clk,
  input logic        arst_n,
  input logic        pdec_psel,
  input logic        pdec_penable,
  input logic        pdec_pwrite,
  input logic [31:0] pdec_paddr,
  input logic [31:0] pdec_pwdata,
  input logic [31:0] pdec_prdata,
  input logic        pdec_pready,
  input logic        pdec_pslverr,
  input logic        pdec_sram_wen,
  input logic [12:0] pdec_sram_waddr,
  input logic [31:0] pdec_sram_wdata,
  input logic        pdec_sram_ren,
  input logic [12:0] pdec_sram_raddr,
  input logic [31:0] pdec_sram_rdata,
  input logic        pdec_int,
  input logic        busy,
  input logic        para_st
);

  int           fail_cnt = 0;
  logic [31:0]  shadow [256];
  logic [255:0] written;
  logic [7:0]   base_sh;
  logic [7:0]   fetch_base;
  logic         int_en_sh;
  logic         int_en_q;
  logic         fetched;
  logic         rd_q;
  logic         rd_chk_q;
  logic         rd_chk_qq;
  logic [31:0]  rd_exp_q;
  logic [31:0]  rd_exp_qq;
  logic [7:0]   off;
  logic [7:0]   raddr8;
  logic         access;
  logic         hi_ok;
  logic         mapped;
  logic         writable;
  logic         rd_chk;
  logic         exp_err;
  logic         legal_wr;
  logic [31:0]  exp_rd;

  task automatic count_failure(input string msg);
    fail_cnt++;
    $error("CHECK FAILED %0t: %s", $time, msg);
  endtask

  // ==================================================
  // expected register map
  // ==================================================
  assign off      = pdec_paddr[7:0];
  assign hi_ok    = (pdec_paddr[31:8] == '0);
  assign access   = pdec_psel & pdec_penable;
  assign raddr8   = pdec_sram_raddr[7:0];
  assign exp_err  = ~hi_ok | ~mapped | (pdec_pwrite & ~writable);
  assign legal_wr = access & pdec_pwrite & ~exp_err;

  always_comb begin
    mapped   = 1'b1;
    writable = 1'b0;
    rd_chk   = 1'b1;
    exp_rd   = '0;
    case (off)
      pdec_cfg_pkg::OFF_VERSION: exp_rd = '0;
      pdec_cfg_pkg::OFF_CTRL: begin
        writable = 1'b1;
        exp_rd   = {30'd0, int_en_sh, 1'b0};
      end
      // done and busy follow the fetch
      pdec_cfg_pkg::OFF_STATUS: begin
        writable = 1'b1;
        rd_chk   = 1'b0;
      end
      pdec_cfg_pkg::OFF_PARA_BASE: begin
        writable = 1'b1;
        exp_rd   = {24'd0, base_sh};
      end
      pdec_cfg_pkg::OFF_PARAM_N: begin
        rd_chk = ~busy;
        exp_rd = fetched ? {29'd0, shadow[fetch_base][2:0]} : '0;
      end
      pdec_cfg_pkg::OFF_PARAM_A: begin
        rd_chk = ~busy;
        exp_rd = fetched ? {24'd0, shadow[fetch_base + 8'd1][7:0]} : '0;
      end
      pdec_cfg_pkg::OFF_PARAM_K: begin
        rd_chk = ~busy;
        exp_rd = fetched ? {24'd0, shadow[fetch_base + 8'd2][7:0]} : '0;
      end
      default: mapped = 1'b0;
    endcase
    if (!hi_ok) begin
      rd_chk = 1'b1;
      exp_rd = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      written    <= '0;
      base_sh    <= '0;
      fetch_base <= '0;
      int_en_sh  <= 1'b0;
      int_en_q   <= 1'b0;
      fetched    <= 1'b0;
      rd_q       <= 1'b0;
      rd_chk_q   <= 1'b0;
      rd_chk_qq  <= 1'b0;
    end else begin
      if (pdec_sram_wen && (int'(pdec_sram_waddr[7:0]) < PARA_NUM)) begin
        shadow[pdec_sram_waddr[7:0]]  <= pdec_sram_wdata;
        written[pdec_sram_waddr[7:0]] <= 1'b1;
      end
      if (legal_wr && (off == pdec_cfg_pkg::OFF_CTRL)) begin
        int_en_sh <= pdec_pwdata[1];
      end
      if (legal_wr && (off == pdec_cfg_pkg::OFF_PARA_BASE)) begin
        base_sh <= pdec_pwdata[7:0];
      end
      int_en_q <= int_en_sh;
      // a start pulse seen while idle begins a fetch
      if (para_st && !busy) begin
        fetched    <= 1'b1;
        fetch_base <= base_sh;
      end
      rd_q      <= pdec_sram_ren && !pdec_sram_wen;
      rd_chk_q  <= pdec_sram_ren && !pdec_sram_wen &&
                   ((int'(raddr8) >= PARA_NUM) || written[raddr8]);
      rd_exp_q  <= (int'(raddr8) >= PARA_NUM) ? '0 : shadow[raddr8];
      // host read data stays until the next host read
      if (rd_q) begin
        rd_chk_qq <= rd_chk_q;
        rd_exp_qq <= rd_exp_q;
      end
    end
  end

  // ==================================================
  // assertions
  // ==================================================
  pready_high: assert property (@(posedge clk) disable iff (!arst_n) pdec_pready)
    else count_failure("pready low");

  slverr_map: assert property (@(posedge clk) disable iff (!arst_n)
    access |-> (pdec_pslverr == exp_err))
    else count_failure("pslverr does not match the register map");

  apb_read_data: assert property (@(posedge clk) disable iff (!arst_n)
    (access && !pdec_pwrite && rd_chk) |-> (pdec_prdata == exp_rd))
    else count_failure("APB read data mismatch");

  host_read_data: assert property (@(posedge clk) disable iff (!arst_n)
    rd_chk_qq |-> (pdec_sram_rdata == rd_exp_qq))
    else count_failure("host read data mismatch");

  int_needs_en: assert property (@(posedge clk) disable iff (!arst_n)
    pdec_int |-> int_en_q)
    else count_failure("pdec_int high with int_en low");

  done_at_busy_end: assert property (@(posedge clk) disable iff (!arst_n)
    ($fell(busy) && int_en_sh) |-> ##1 pdec_int)
    else count_failure("no interrupt when the fetch ended");

  clear_drops_int: assert property (@(posedge clk) disable iff (!arst_n)
    (legal_wr && (off == pdec_cfg_pkg::OFF_STATUS) && pdec_pwdata[0] && !busy)
      |-> ##2 !pdec_int)
    else count_failure("pdec_int still high after done clear");

  busy_after_start: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(busy) |-> $past(para_st))
    else count_failure("busy rose without a start pulse");

endmodule

bind pdec_wrap pdec_wrap_assertions #(
  .PARA_NUM (PARA_NUM)
) u_assertions (
  .clk             (clk),
  .arst_n          (arst_n),
  .pdec_psel       (pdec_psel),
  .pdec_penable    (pdec_penable),
  .pdec_pwrite     (pdec_pwrite),
  .pdec_paddr      (pdec_paddr),
  .pdec_pwdata     (pdec_pwdata),
  .pdec_prdata     (pdec_prdata),
  .pdec_pready     (pdec_pready),
  .pdec_pslverr    (pdec_pslverr),
  .pdec_sram_wen   (pdec_sram_wen),
  .pdec_sram_waddr (pdec_sram_waddr),
  .pdec_sram_wdata (pdec_sram_wdata),
  .pdec_sram_ren   (pdec_sram_ren),
  .pdec_sram_raddr (pdec_sram_raddr),
  .pdec_sram_rdata (pdec_sram_rdata),
  .pdec_int        (pdec_int),
  .busy            (busy),
  .para_st         (para_st)
);

`default_nettype wire

// File: test/tb_pdec_wrap.sv
// Testbench for pdec_wrap: APB and host port stimulus, run limit and summary.
// The bound checker does the value checks; its count is read at the end.
`timescale 1ns/1ps
`default_nettype none

module tb_pdec_wrap;

  localparam int PARA_NUM   = 155;
  localparam int MAX_CYCLES = 2000;
  localparam int INT_WAIT   = 200;

  logic        clk;
  logic        arst_n;
  logic        pdec_psel;
  logic        pdec_penable;
  logic        pdec_pwrite;
  logic [31:0] pdec_paddr;
  logic [31:0] pdec_pwdata;
  logic [31:0] pdec_prdata;
  logic        pdec_pready;
  logic        pdec_pslverr;
  logic        pdec_sram_wen;
  logic [12:0] pdec_sram_waddr;
  logic [31:0] pdec_sram_wdata;
  logic        pdec_sram_ren;
  logic [12:0] pdec_sram_raddr;
  logic [31:0] pdec_sram_rdata;
  logic        pdec_int;
  int          cycles;
  int          tb_errs;
  logic        traffic_on;
  logic [31:0] rdata;
  logic [7:0]  base;

  pdec_wrap #(
    .PARA_NUM (PARA_NUM)
  ) UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .pdec_psel       (pdec_psel),
    .pdec_penable    (pdec_penable),
    .pdec_pwrite     (pdec_pwrite),
    .pdec_paddr      (pdec_paddr),
    .pdec_pwdata     (pdec_pwdata),
    .pdec_prdata     (pdec_prdata),
    .pdec_pready     (pdec_pready),
    .pdec_pslverr    (pdec_pslverr),
    .pdec_sram_wen   (pdec_sram_wen),
    .pdec_sram_waddr (pdec_sram_waddr),
    .pdec_sram_wdata (pdec_sram_wdata),
    .pdec_sram_ren   (pdec_sram_ren),
    .pdec_sram_raddr (pdec_sram_raddr),
    .pdec_sram_rdata (pdec_sram_rdata),
    .pdec_int        (pdec_int)
  );

  always #4 clk = ~clk;

  task automatic finish_run();
    int chk_errs;
    chk_errs = UUT.u_assertions.fail_cnt;
    $display("errors: assertions %0d, testbench %0d", chk_errs, tb_errs);
    if ((chk_errs == 0) && (tb_errs == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      tb_errs++;
      $display("timeout: run stopped after %0d cycles", cycles);
      finish_run();
    end
  end

  // ==================================================
  // bus tasks
  // ==================================================
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    pdec_psel   = 1'b1;
    pdec_pwrite = 1'b1;
    pdec_paddr  = addr;
    pdec_pwdata = data;
    @(negedge clk);
    pdec_penable = 1'b1;
    @(negedge clk);
    pdec_psel    = 1'b0;
    pdec_penable = 1'b0;
    pdec_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge clk);
    pdec_psel   = 1'b1;
    pdec_pwrite = 1'b0;
    pdec_paddr  = addr;
    @(negedge clk);
    pdec_penable = 1'b1;
    data         = pdec_prdata;
    @(negedge clk);
    pdec_psel    = 1'b0;
    pdec_penable = 1'b0;
  endtask

  task automatic host_write(input logic [12:0] addr, input logic [31:0] data);
    @(negedge clk);
    pdec_sram_wen   = 1'b1;
    pdec_sram_waddr = addr;
    pdec_sram_wdata = data;
    @(negedge clk);
    pdec_sram_wen = 1'b0;
  endtask

  // read of the same address in the cycle right after the write
  task automatic host_write_read(input logic [12:0] addr, input logic [31:0] data);
    @(negedge clk);
    pdec_sram_wen   = 1'b1;
    pdec_sram_waddr = addr;
    pdec_sram_wdata = data;
    @(negedge clk);
    pdec_sram_wen   = 1'b0;
    pdec_sram_ren   = 1'b1;
    pdec_sram_raddr = addr;
    @(negedge clk);
    pdec_sram_ren = 1'b0;
  endtask

  task automatic wait_int(input int limit);
    int n;
    n = 0;
    while (!pdec_int && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (!pdec_int) begin
      tb_errs++;
      $display("pdec_int did not rise within %0d cycles", limit);
    end
  endtask

  // random host address outside the three fetched words
  function automatic logic [12:0] pick_addr(input logic [7:0] b);
    logic [7:0] a;
    a = 8'($urandom_range(0, 170));
    if ((a >= b) && (a <= b + 8'd2)) begin
      a = a + 8'd3;
    end
    return 13'(a);
  endfunction

  task automatic host_traffic(input logic [7:0] b);
    int op;
    while (traffic_on) begin
      op = $urandom_range(0, 2);
      @(negedge clk);
      pdec_sram_wen   = (op != 1);
      pdec_sram_waddr = pick_addr(b);
      pdec_sram_wdata = $urandom;
      pdec_sram_ren   = (op != 0);
      pdec_sram_raddr = pick_addr(b);
      @(negedge clk);
      pdec_sram_wen = 1'b0;
      pdec_sram_ren = 1'b0;
    end
  endtask

  // ==================================================
  // test sequences
  // ==================================================
  task automatic check_apb_map();
    apb_read(pdec_cfg_pkg::OFF_VERSION, rdata);
    apb_read(32'h0000_001C, rdata);
    apb_write(32'h0000_0020, $urandom);
    apb_write(pdec_cfg_pkg::OFF_PARAM_K, $urandom);
    apb_write(pdec_cfg_pkg::OFF_VERSION, 32'hFFFF_FFFF);
    // upper address bits set, must not reach CTRL
    apb_write(32'h0000_0104, 32'h3);
    apb_read(32'h0000_0104, rdata);
    apb_read(pdec_cfg_pkg::OFF_CTRL, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARA_BASE, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARAM_N, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARAM_A, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARAM_K, rdata);
  endtask

  task automatic check_host_mem();
    logic [12:0] a;
    repeat (12) begin
      a = 13'($urandom_range(0, PARA_NUM - 1));
      host_write_read(a, $urandom);
    end
    repeat (6) begin
      a = 13'($urandom_range(PARA_NUM, 255));
      host_write_read(a, $urandom);
    end
  endtask

  task automatic run_fetch(input logic [7:0] b, input logic with_traffic);
    host_write(13'(b), $urandom);
    host_write(13'(b + 8'd1), $urandom);
    host_write(13'(b + 8'd2), $urandom);
    apb_write(pdec_cfg_pkg::OFF_PARA_BASE, 32'(b));
    traffic_on = with_traffic;
    fork
      begin
        apb_write(pdec_cfg_pkg::OFF_CTRL, 32'h3);
        wait_int(INT_WAIT);
        traffic_on = 1'b0;
      end
      host_traffic(b);
    join
    apb_read(pdec_cfg_pkg::OFF_PARAM_N, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARAM_A, rdata);
    apb_read(pdec_cfg_pkg::OFF_PARAM_K, rdata);
    apb_write(pdec_cfg_pkg::OFF_STATUS, 32'h1);
  endtask

  task automatic check_int_ctrl();
    int n;
    apb_write(pdec_cfg_pkg::OFF_CTRL, 32'h1);
    n     = 0;
    rdata = '0;
    while (!rdata[0] && (n < INT_WAIT)) begin
      apb_read(pdec_cfg_pkg::OFF_STATUS, rdata);
      n++;
    end
    if (!rdata[0]) begin
      tb_errs++;
      $display("done bit never set after a start with int_en low");
    end
    repeat (4) @(negedge clk);
    apb_write(pdec_cfg_pkg::OFF_CTRL, 32'h2);
    wait_int(INT_WAIT);
    apb_write(pdec_cfg_pkg::OFF_STATUS, 32'h1);
    // second start lands while the first fetch is busy
    apb_write(pdec_cfg_pkg::OFF_CTRL, 32'h3);
    apb_write(pdec_cfg_pkg::OFF_CTRL, 32'h3);
    wait_int(INT_WAIT);
    apb_write(pdec_cfg_pkg::OFF_STATUS, 32'h1);
    repeat (2) @(negedge clk);
    repeat (24) begin
      @(negedge clk);
      if (pdec_int) begin
        tb_errs++;
        $display("pdec_int rose again after a start written while busy");
      end
    end
  endtask

  initial begin
    int seed;
    seed            = $urandom(32'h6114_1918);
    clk             = 1'b0;
    arst_n          = 1'b0;
    pdec_psel       = 1'b0;
    pdec_penable    = 1'b0;
    pdec_pwrite     = 1'b0;
    pdec_paddr      = '0;
    pdec_pwdata     = '0;
    pdec_sram_wen   = 1'b0;
    pdec_sram_waddr = '0;
    pdec_sram_wdata = '0;
    pdec_sram_ren   = 1'b0;
    pdec_sram_raddr = '0;
    cycles          = 0;
    tb_errs         = 0;
    traffic_on      = 1'b0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    check_apb_map();
    check_host_mem();
    base = 8'($urandom_range(0, PARA_NUM - 3));
    run_fetch(base, 1'b0);
    base = 8'($urandom_range(0, PARA_NUM - 3));
    run_fetch(base, 1'b1);
    check_int_ctrl();
    repeat (4) @(negedge clk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: build.f
common/pdec_cfg_pkg.sv
common/pdec_mem_pkg.sv
sram/pdec_para_sram.sv
sram/pdec_sram_arb.sv
hdl/pdec_para_fetch.sv
apb_regs/pdec_apb_regs.sv
hdl/pdec_wrap.sv
test/pdec_wrap_assertions.sv
test/tb_pdec_wrap.sv

// File: Bender.yml
package:
  name: pdec_wrap

sources:
  - common/pdec_cfg_pkg.sv
  - common/pdec_mem_pkg.sv
  - sram/pdec_para_sram.sv
  - sram/pdec_sram_arb.sv
  - hdl/pdec_para_fetch.sv
  - apb_regs/pdec_apb_regs.sv
  - hdl/pdec_wrap.sv
  - target: test
    files:
      - test/pdec_wrap_assertions.sv
      - test/tb_pdec_wrap.sv
